//--- src/ov7670_edge_pkg.sv
/*
  ov7670 edge path shared types
  gray pixel width, buffer write bundle, stream beat and processing modes
*/
package ov7670_edge_pkg;

  // gray level width, luma only
  localparam int c_nb_pxl = 8;
  // widest address field, 80x60 needs 13 bits
  localparam int c_nb_addr_max = 13;

  // processing modes, stepped by the control button
  typedef enum logic [1:0] {
    mode_pass,
    mode_hor,
    mode_ver
  } proc_mode_t;

  // write port bundle toward a frame buffer
  typedef struct packed {
    logic                     we;
    logic [c_nb_addr_max-1:0] addr;
    logic [c_nb_pxl-1:0]      data;
  } pxl_wr_t;

  // one beat of the output stream
  typedef struct packed {
    logic [c_nb_pxl-1:0] data;
    logic                last;
  } pxl_beat_t;

endpackage

//--- src/ov7670_capture.sv
/*
  ov7670 yuv capture
  keeps the luma byte of each pixel and writes it in raster order
*/
`timescale 1ns/1ps

module ov7670_capture
  import ov7670_edge_pkg::*;
#(
  parameter int c_img_cols    = 80,
  parameter int c_img_rows    = 60,
  parameter int c_nb_img_pxls = 13
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                pclk,
  input  logic                vsync,
  input  logic                href,
  input  logic [c_nb_pxl-1:0] data,
  output pxl_wr_t             cap_wr,
  output logic                frame_done
);

  // address of the last pixel of a frame
  localparam logic [c_nb_img_pxls-1:0] c_last_addr =
    c_nb_img_pxls'(c_img_cols * c_img_rows - 1);

  logic [1:0]               pclk_s, vsync_s, href_s;
  logic [c_nb_pxl-1:0]      data_s0, data_s1;
  logic                     pclk_d, vsync_d;
  logic                     pclk_rise, vsync_rise, vsync_fall;
  logic                     in_frame;
  // low on the luma byte of a pair
  logic                     byte_phase;
  logic [c_nb_img_pxls-1:0] addr_cnt;
  logic                     full, ovf;

  // two-stage synchronizers, then one more stage for edges
  always_ff @(posedge clk) begin
    if (rst) begin
      pclk_s  <= '0;
      vsync_s <= '0;
      href_s  <= '0;
      pclk_d  <= 1'b0;
      vsync_d <= 1'b0;
    end else begin
      pclk_s  <= {pclk_s[0], pclk};
      vsync_s <= {vsync_s[0], vsync};
      href_s  <= {href_s[0], href};
      pclk_d  <= pclk_s[1];
      vsync_d <= vsync_s[1];
    end
  end

  // data byte follows the same two stages as pclk
  always_ff @(posedge clk) begin
    data_s0 <= data;
    data_s1 <= data_s0;
  end

  assign pclk_rise  = pclk_s[1] & ~pclk_d;
  assign vsync_rise = vsync_s[1] & ~vsync_d;
  assign vsync_fall = ~vsync_s[1] & vsync_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame   <= 1'b0;
      byte_phase <= 1'b0;
      addr_cnt   <= '0;
      full       <= 1'b0;
      ovf        <= 1'b0;
      frame_done <= 1'b0;
      cap_wr     <= '0;
    end else begin
      frame_done <= 1'b0;
      cap_wr.we  <= 1'b0;
      // falling vsync opens a frame
      if (vsync_fall) begin
        in_frame <= 1'b1;
        addr_cnt <= '0;
        full     <= 1'b0;
        ovf      <= 1'b0;
      end else if (vsync_rise) begin
        in_frame <= 1'b0;
        // only a frame of exactly the right size is announced
        frame_done <= in_frame & full & ~ovf;
      end
      if (!href_s[1]) begin
        byte_phase <= 1'b0;
      end else if (pclk_rise) begin
        byte_phase <= ~byte_phase;
        if (!byte_phase && in_frame) begin
          if (full) begin
            ovf <= 1'b1;
          end else begin
            cap_wr   <= '{we: 1'b1, addr: c_nb_addr_max'(addr_cnt), data: data_s1};
            addr_cnt <= addr_cnt + 1'b1;
            full     <= (addr_cnt == c_last_addr);
          end
        end
      end
    end
  end

endmodule

//--- src/frame_buffer.sv
/*
  frame buffer, simple dual-port ram
  one write port, registered read with one cycle latency
*/
`timescale 1ns/1ps

module frame_buffer
  import ov7670_edge_pkg::*;
#(
  parameter int c_nb_img_pxls = 13,
  parameter int c_img_pxls    = 4800
) (
  input  logic                     clk,
  input  pxl_wr_t                  wr,
  input  logic [c_nb_img_pxls-1:0] rd_addr,
  output logic [c_nb_pxl-1:0]      rd_data
);

  logic [c_nb_pxl-1:0] mem [c_img_pxls];

  // read before write on the same address
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr[c_nb_img_pxls-1:0]] <= wr.data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

//--- src/proc_mode_regs.sv
/*
  processing mode register
  each button press steps pass, horizontal, vertical, then pass again
*/
`timescale 1ns/1ps

module proc_mode_regs
  import ov7670_edge_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       btn,
  output proc_mode_t mode
);

  logic [1:0] btn_s;
  logic       btn_d;
  logic       press;

  // button is asynchronous
  always_ff @(posedge clk) begin
    if (rst) begin
      btn_s <= '0;
      btn_d <= 1'b0;
    end else begin
      btn_s <= {btn_s[0], btn};
      btn_d <= btn_s[1];
    end
  end

  assign press = btn_s[1] & ~btn_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      mode <= mode_pass;
    end else if (press) begin
      case (mode)
        mode_pass: mode <= mode_hor;
        mode_hor:  mode <= mode_ver;
        default:   mode <= mode_pass;
      endcase
    end
  end

endmodule

//--- src/edge_proc.sv
/*
  frame-sequential sobel engine
  copies or takes the horizontal or vertical gradient of a stored frame
*/
`timescale 1ns/1ps

module edge_proc
  import ov7670_edge_pkg::*;
#(
  parameter int c_img_cols    = 80,
  parameter int c_img_rows    = 60,
  parameter int c_nb_img_pxls = 13
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     frame_done,
  input  logic                     rd_busy,
  input  proc_mode_t               mode,
  input  logic [c_nb_pxl-1:0]      orig_pxl,
  output logic [c_nb_img_pxls-1:0] orig_addr,
  output pxl_wr_t                  proc_wr,
  output logic                     proc_done
);

  localparam logic [c_nb_img_pxls-1:0] c_last_addr =
    c_nb_img_pxls'(c_img_cols * c_img_rows - 1);
  localparam logic [c_nb_img_pxls-1:0] c_last_col = c_nb_img_pxls'(c_img_cols - 1);
  localparam logic [c_nb_img_pxls-1:0] c_last_row = c_nb_img_pxls'(c_img_rows - 1);

  typedef enum logic [1:0] {st_idle, st_pass, st_grad, st_flush} state_t;

  state_t                   state;
  proc_mode_t               mode_l;
  logic [c_nb_img_pxls-1:0] pix_addr, col, row, rd_vld_addr;
  logic [2:0]               tap, tap_k;
  logic                     rd_vld, border, last_pix, pix_adv;
  logic signed [11:0]       acc, term, acc_sum;
  logic [11:0]              acc_abs;
  logic [c_nb_pxl-1:0]      grad_pxl;

  // taps 0..2 on the positive side, 3..5 on the negative side
  function automatic logic [c_nb_img_pxls-1:0] tap_addr(
    input proc_mode_t               m,
    input logic [2:0]               t,
    input logic [c_nb_img_pxls-1:0] base
  );
    int side;
    int pos;
    int dr;
    int dc;
    side = (t < 3'd3) ? 1 : -1;
    pos  = int'(t) % 3 - 1;
    if (m == mode_hor) begin
      dr = pos;
      dc = side;
    end else begin
      dr = side;
      dc = pos;
    end
    return base + c_nb_img_pxls'(dr * c_img_cols + dc);
  endfunction

  assign border   = (col == '0) || (col == c_last_col) || (row == '0) || (row == c_last_row);
  assign last_pix = (pix_addr == c_last_addr);
  assign pix_adv  = (state == st_pass) || ((state == st_grad) && (border || tap == 3'd6));

  // pass reads straight through, gradient walks the six taps
  assign orig_addr = (state == st_grad) ? tap_addr(mode_l, tap, pix_addr) : pix_addr;

  // data arriving now belongs to the previous tap
  assign tap_k = tap - 3'd1;

  always_comb begin
    term = (int'(tap_k) % 3 == 1) ? $signed({3'b0, orig_pxl, 1'b0})
                                  : $signed({4'b0, orig_pxl});
    if (tap_k >= 3'd3) begin
      term = -term;
    end
    acc_sum  = acc + term;
    acc_abs  = (acc_sum < 0) ? 12'(-acc_sum) : 12'(acc_sum);
    // saturate at full white
    grad_pxl = (acc_abs > 12'd255) ? 8'hff : acc_abs[7:0];
  end

  // raster counters, held at zero while idle
  always_ff @(posedge clk) begin
    if (rst || state == st_idle) begin
      pix_addr <= '0;
      col      <= '0;
      row      <= '0;
    end else if (pix_adv) begin
      pix_addr <= pix_addr + 1'b1;
      if (col == c_last_col) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // accumulator and address of the read in flight
  always_ff @(posedge clk) begin
    rd_vld_addr <= pix_addr;
    if (tap == 3'd0) begin
      acc <= '0;
    end else begin
      acc <= acc_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      mode_l    <= mode_pass;
      tap       <= '0;
      rd_vld    <= 1'b0;
      proc_done <= 1'b0;
      proc_wr   <= '0;
    end else begin
      proc_done  <= 1'b0;
      proc_wr.we <= 1'b0;
      rd_vld     <= (state == st_pass);
      // copy write, one cycle behind its read
      if (rd_vld) begin
        proc_wr <= '{we: 1'b1, addr: c_nb_addr_max'(rd_vld_addr), data: orig_pxl};
      end
      case (state)
        st_idle: begin
          // frame dropped while busy or the reader is still streaming
          if (frame_done && !rd_busy) begin
            mode_l <= mode;
            tap    <= '0;
            state  <= (mode == mode_pass) ? st_pass : st_grad;
          end
        end
        st_pass: begin
          if (last_pix) begin
            state <= st_flush;
          end
        end
        st_grad: begin
          if (border) begin
            proc_wr <= '{we: 1'b1, addr: c_nb_addr_max'(pix_addr), data: '0};
          end else if (tap == 3'd6) begin
            proc_wr <= '{we: 1'b1, addr: c_nb_addr_max'(pix_addr), data: grad_pxl};
            tap     <= '0;
          end else begin
            tap <= tap + 3'd1;
          end
          if (pix_adv && last_pix) begin
            state <= st_flush;
          end
        end
        default: begin
          // last copy write lands here
          proc_done <= 1'b1;
          state     <= st_idle;
        end
      endcase
    end
  end

endmodule

//--- src/frame_reader.sv
/*
  processed frame reader
  streams the buffer with valid/ready, holding a beat under back-pressure
*/
`timescale 1ns/1ps

module frame_reader
  import ov7670_edge_pkg::*;
#(
  parameter int c_img_pxls    = 4800,
  parameter int c_nb_img_pxls = 13
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     proc_done,
  input  logic [c_nb_pxl-1:0]      rd_pxl,
  input  logic                     out_ready,
  output logic [c_nb_img_pxls-1:0] rd_addr,
  output logic                     rd_busy,
  output pxl_beat_t                out_beat,
  output logic                     out_valid
);

  localparam logic [c_nb_img_pxls-1:0] c_last_addr = c_nb_img_pxls'(c_img_pxls - 1);

  logic      issue, issue_done, out_free;
  logic      rd_vld, rd_last, hold_valid;
  pxl_beat_t rd_beat, hold_beat;

  // a new read only while the sink takes data and the hold is empty
  assign issue    = rd_busy & ~issue_done & out_ready & ~hold_valid;
  assign out_free = ~out_valid | out_ready;
  assign rd_beat  = '{data: rd_pxl, last: rd_last};

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr    <= '0;
      rd_busy    <= 1'b0;
      issue_done <= 1'b0;
      rd_vld     <= 1'b0;
      hold_valid <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      rd_vld <= issue;
      if (proc_done) begin
        rd_busy    <= 1'b1;
        issue_done <= 1'b0;
        rd_addr    <= '0;
      end else if (issue) begin
        rd_addr <= rd_addr + 1'b1;
        if (rd_addr == c_last_addr) begin
          issue_done <= 1'b1;
        end
      end
      // busy ends with the last transfer
      if (out_valid && out_ready && out_beat.last) begin
        rd_busy <= 1'b0;
      end
      if (out_free) begin
        out_valid  <= hold_valid | rd_vld;
        hold_valid <= 1'b0;
      end else if (rd_vld) begin
        // read in flight caught by a stall
        hold_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      rd_last <= (rd_addr == c_last_addr);
    end
    if (out_free) begin
      out_beat <= hold_valid ? hold_beat : rd_beat;
    end else if (rd_vld) begin
      hold_beat <= rd_beat;
    end
  end

endmodule

//--- src/ov7670_edge_top.sv
/*
  ov7670 edge image top level
  capture, two frame buffers, sobel engine, mode register and stream reader
*/
`timescale 1ns/1ps

module ov7670_edge_top
  import ov7670_edge_pkg::*;
#(
  parameter int c_img_cols    = 80,
  parameter int c_img_rows    = 60,
  parameter int c_nb_img_pxls = 13
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                proc_ctrl,
  input  logic                ov7670_pclk,
  input  logic                ov7670_vsync,
  input  logic                ov7670_href,
  input  logic [c_nb_pxl-1:0] ov7670_d,
  output pxl_beat_t           out_beat,
  output logic                out_valid,
  input  logic                out_ready
);

  localparam int c_img_pxls = c_img_cols * c_img_rows;

  pxl_wr_t                  cap_wr, proc_wr;
  logic [c_nb_img_pxls-1:0] orig_addr, rd_addr;
  logic [c_nb_pxl-1:0]      orig_pxl, rd_pxl;
  logic                     frame_done, proc_done, rd_busy;
  proc_mode_t               mode;

  ov7670_capture #(
    .c_img_cols   (c_img_cols),
    .c_img_rows   (c_img_rows),
    .c_nb_img_pxls(c_nb_img_pxls)
  ) i_capture (
    .clk       (clk),
    .rst       (rst),
    .pclk      (ov7670_pclk),
    .vsync     (ov7670_vsync),
    .href      (ov7670_href),
    .data      (ov7670_d),
    .cap_wr    (cap_wr),
    .frame_done(frame_done)
  );

  // camera frame, before processing
  frame_buffer #(.c_nb_img_pxls(c_nb_img_pxls), .c_img_pxls(c_img_pxls)) i_cam_fb (
    .clk    (clk),
    .wr     (cap_wr),
    .rd_addr(orig_addr),
    .rd_data(orig_pxl)
  );

  proc_mode_regs i_mode_regs (
    .clk (clk),
    .rst (rst),
    .btn (proc_ctrl),
    .mode(mode)
  );

  edge_proc #(
    .c_img_cols   (c_img_cols),
    .c_img_rows   (c_img_rows),
    .c_nb_img_pxls(c_nb_img_pxls)
  ) i_edge_proc (
    .clk       (clk),
    .rst       (rst),
    .frame_done(frame_done),
    .rd_busy   (rd_busy),
    .mode      (mode),
    .orig_pxl  (orig_pxl),
    .orig_addr (orig_addr),
    .proc_wr   (proc_wr),
    .proc_done (proc_done)
  );

  // processed frame
  frame_buffer #(.c_nb_img_pxls(c_nb_img_pxls), .c_img_pxls(c_img_pxls)) i_proc_fb (
    .clk    (clk),
    .wr     (proc_wr),
    .rd_addr(rd_addr),
    .rd_data(rd_pxl)
  );

  frame_reader #(.c_img_pxls(c_img_pxls), .c_nb_img_pxls(c_nb_img_pxls)) i_reader (
    .clk      (clk),
    .rst      (rst),
    .proc_done(proc_done),
    .rd_pxl   (rd_pxl),
    .out_ready(out_ready),
    .rd_addr  (rd_addr),
    .rd_busy  (rd_busy),
    .out_beat (out_beat),
    .out_valid(out_valid)
  );

endmodule

//--- tests/ov7670_edge_chk.sv
/*
  stream protocol and reset checks for the ov7670 edge top
*/
`timescale 1ns/1ps

module ov7670_edge_chk
  import ov7670_edge_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      out_valid,
  input logic      out_ready,
  input logic      rd_busy,
  input pxl_beat_t out_beat,
  input pxl_wr_t   cap_wr,
  input pxl_wr_t   proc_wr
);

  // assertion failures so far
  int fail_cnt;

  // quiet outputs and write ports one cycle into reset
  reset_quiet: assert property (@(posedge clk)
    rst |=> !out_valid && !rd_busy && !cap_wr.we && !proc_wr.we)
    else begin
      fail_cnt++;
      $error("stream or write port active after reset");
    end

  // a stalled beat holds valid and payload
  stall_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
      fail_cnt++;
      $error("stalled beat changed before its transfer");
    end

  // idle cycle after the last beat of a frame
  last_gap: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && out_beat.last |=> !out_valid)
    else begin
      fail_cnt++;
      $error("no gap after the last beat of a frame");
    end

  // beats only while the reader owns the buffer
  valid_in_busy: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> rd_busy)
    else begin
      fail_cnt++;
      $error("valid beat outside a reader pass");
    end

endmodule

bind ov7670_edge_top ov7670_edge_chk i_chk (
  .clk      (clk),
  .rst      (rst),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .rd_busy  (rd_busy),
  .out_beat (out_beat),
  .cap_wr   (cap_wr),
  .proc_wr  (proc_wr)
);

//--- tests/tb_ov7670_edge.sv
/*
  testbench for the ov7670 edge path
  camera model, mode button, sobel reference model and stream scoreboard
*/
`timescale 1ns/1ps

module tb_ov7670_edge
  import ov7670_edge_pkg::*;
();

  localparam int c_cols    = 8;
  localparam int c_rows    = 6;
  localparam int c_nb_addr = 6;
  localparam int c_pxls    = c_cols * c_rows;
  localparam int c_frames  = 8;
  // about 1500 cycles per frame incl. processing and a slow sink, plus margin
  localparam int c_timeout = c_frames * 1500 + 8000;
  localparam logic [31:0] c_seed = 32'ha84a_2f61;

  logic        clk, rst, proc_ctrl;
  logic        cam_pclk, cam_vsync, cam_href;
  logic [7:0]  cam_d;
  pxl_beat_t   out_beat, exp_beat;
  logic        out_valid, out_ready;

  // luma of the frame being sent
  logic [7:0]  frame_px [c_pxls];
  pxl_beat_t   exp_q [$];
  logic [31:0] cam_st, rdy_st;
  // sink always ready (0), random (1) or stalled (2)
  logic [1:0]  ready_mode;
  int          tb_mode, exp_frames, beat_cnt, err_cnt, cycle_cnt;

  ov7670_edge_top #(
    .c_img_cols   (c_cols),
    .c_img_rows   (c_rows),
    .c_nb_img_pxls(c_nb_addr)
  ) ov7670_edge_top_i (
    .clk         (clk),
    .rst         (rst),
    .proc_ctrl   (proc_ctrl),
    .ov7670_pclk (cam_pclk),
    .ov7670_vsync(cam_vsync),
    .ov7670_href (cam_href),
    .ov7670_d    (cam_d),
    .out_beat    (out_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int px(input int r, input int c);
    return int'(frame_px[r * c_cols + c]);
  endfunction

  // 0 copy, 1 right minus left column, 2 lower minus upper row
  function automatic logic [7:0] ref_pixel(input int m, input int r, input int c);
    int gp;
    int gn;
    int g;
    if (m == 0) begin
      return frame_px[r * c_cols + c];
    end
    if (r == 0 || c == 0 || r == c_rows - 1 || c == c_cols - 1) begin
      return 8'h00;
    end
    if (m == 1) begin
      gp = px(r - 1, c + 1) + 2 * px(r, c + 1) + px(r + 1, c + 1);
      gn = px(r - 1, c - 1) + 2 * px(r, c - 1) + px(r + 1, c - 1);
    end else begin
      gp = px(r + 1, c - 1) + 2 * px(r + 1, c) + px(r + 1, c + 1);
      gn = px(r - 1, c - 1) + 2 * px(r - 1, c) + px(r - 1, c + 1);
    end
    g = (gp > gn) ? gp - gn : gn - gp;
    return (g > 255) ? 8'hff : 8'(g);
  endfunction

  task automatic push_expected(input int m);
    pxl_beat_t b;
    for (int i = 0; i < c_pxls; i++) begin
      b.data = ref_pixel(m, i / c_cols, i % c_cols);
      b.last = (i == c_pxls - 1);
      exp_q.push_back(b);
    end
    exp_frames++;
  endtask

  // one byte per pclk period of 8 clk cycles
  task automatic send_byte(input logic [7:0] b);
    cam_d    <= b;
    cam_pclk <= 1'b0;
    repeat (4) @(posedge clk);
    cam_pclk <= 1'b1;
    repeat (4) @(posedge clk);
  endtask

  task automatic send_frame(input logic processed);
    int idx;
    idx = 0;
    cam_vsync <= 1'b1;
    repeat (24) @(posedge clk);
    cam_vsync <= 1'b0;
    repeat (16) @(posedge clk);
    for (int r = 0; r < c_rows; r++) begin
      cam_href <= 1'b1;
      for (int b = 0; b < 2 * c_cols; b++) begin
        cam_st = xorshift32(cam_st);
        // luma on even bytes
        if (b % 2 == 0) begin
          frame_px[idx] = cam_st[7:0];
          idx++;
        end
        send_byte(cam_st[7:0]);
      end
      cam_pclk <= 1'b0;
      cam_href <= 1'b0;
      repeat (8) @(posedge clk);
    end
    if (processed) begin
      push_expected(tb_mode);
    end
    // rising vsync closes the frame
    cam_vsync <= 1'b1;
  endtask

  task automatic press_button();
    proc_ctrl <= 1'b1;
    repeat (6) @(posedge clk);
    proc_ctrl <= 1'b0;
    repeat (6) @(posedge clk);
    tb_mode = (tb_mode + 1) % 3;
  endtask

  task automatic wait_stream();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // sink ready pattern
  always @(posedge clk) begin
    if (ready_mode == 2'd1) begin
      rdy_st = xorshift32(rdy_st);
      out_ready <= rdy_st[3];
    end else begin
      out_ready <= (ready_mode == 2'd0);
    end
  end

  // one expected beat per transfer
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("unexpected beat at %0t ns, no frame was pending", $time);
      end else begin
        exp_beat = exp_q.pop_front();
        assert (out_beat == exp_beat) else begin
          err_cnt++;
          $display("ERROR %0t: beat %0d is %h last %b, expected %h last %b", $time,
                   beat_cnt, out_beat.data, out_beat.last, exp_beat.data, exp_beat.last);
        end
      end
      beat_cnt++;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < c_timeout) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run timed out after %0d cycles", cycle_cnt);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    proc_ctrl  = 1'b0;
    cam_pclk   = 1'b0;
    cam_vsync  = 1'b1;
    cam_href   = 1'b0;
    cam_d      = 8'h00;
    out_ready  = 1'b1;
    ready_mode = 2'd0;
    cam_st     = c_seed;
    rdy_st     = c_seed;
    tb_mode    = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // stream idle right after reset
    repeat (4) begin
      @(posedge clk);
      assert (!out_valid) else begin
        err_cnt++;
        $display("ERROR %0t: out_valid high right after reset", $time);
      end
    end
    // first frame in pass mode, then hor, ver and back to pass
    send_frame(1'b1);
    wait_stream();
    repeat (3) begin
      press_button();
      send_frame(1'b1);
      wait_stream();
    end
    // horizontal frame under random back-pressure
    press_button();
    ready_mode <= 2'd1;
    send_frame(1'b1);
    wait_stream();
    // sink stalled, second frame finds the reader busy and is dropped
    ready_mode <= 2'd2;
    send_frame(1'b1);
    send_frame(1'b0);
    ready_mode <= 2'd0;
    wait_stream();
    send_frame(1'b1);
    wait_stream();
    repeat (50) @(posedge clk);
    assert (beat_cnt == exp_frames * c_pxls) else begin
      err_cnt++;
      $display("ERROR %0t: %0d beats received, expected %0d", $time, beat_cnt,
               exp_frames * c_pxls);
    end
    $display("errors: %0d scoreboard, %0d assertion; beats: %0d", err_cnt,
             ov7670_edge_top_i.i_chk.fail_cnt, beat_cnt);
    if (err_cnt == 0 && ov7670_edge_top_i.i_chk.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- ov7670_edge.f
src/ov7670_edge_pkg.sv
src/ov7670_capture.sv
src/frame_buffer.sv
src/proc_mode_regs.sv
src/edge_proc.sv
src/frame_reader.sv
src/ov7670_edge_top.sv
tests/ov7670_edge_chk.sv
tests/tb_ov7670_edge.sv

//--- Makefile
# Verilator build and run for the ov7670 edge path
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_ov7670_edge
FILELIST  = ov7670_edge.f
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
